//--- cpu_wrapper.f
hw/cpu_pkg.sv
hw/axi_lite_pkg.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/cpu_core.sv
hw/axi_lite_master.sv
hw/cpu_wrapper.sv
dv/clk_gen.sv
dv/tb_cpu_wrapper.sv

//--- dv/tb_cpu_wrapper.sv
`default_nettype none

module tb_cpu_wrapper;
  import cpu_pkg::*;
  import axi_lite_pkg::*;

  localparam logic [31:0] SEED = 32'h47e9;
  localparam int MEM_WORDS    = 256;
  localparam int HS_TIMEOUT   = 64;
  localparam int HALT_TIMEOUT = 20000;
  localparam int QUIET_CYCLES = 40;
  localparam int REF_LIMIT    = 1000;
  // Data area, well past the program
  localparam int DATA_BASE    = 32'h240;

  logic                  clk;
  logic                  rst_i;
  logic                  halted_o;
  logic [AXI_ADDR_W-1:0] m_awaddr_o;
  logic                  m_awvalid_o;
  logic                  m_awready_i;
  logic [AXI_DATA_W-1:0] m_wdata_o;
  logic [AXI_STRB_W-1:0] m_wstrb_o;
  logic                  m_wvalid_o;
  logic                  m_wready_i;
  logic [1:0]            m_bresp_i;
  logic                  m_bvalid_i;
  logic                  m_bready_o;
  logic [AXI_ADDR_W-1:0] m_araddr_o;
  logic                  m_arvalid_o;
  logic                  m_arready_i;
  logic [AXI_DATA_W-1:0] m_rdata_i;
  logic [1:0]            m_rresp_i;
  logic                  m_rvalid_i;
  logic                  m_rready_o;

  // Bus memory and the reference copy
  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [XLEN-1:0] ref_mem [MEM_WORDS];
  logic [XLEN-1:0] prog [$];
  logic [XLEN-1:0] exp_addr [$];
  logic [XLEN-1:0] exp_data [$];
  int              n_writes;
  bit              first_read;

  clk_gen #(.PERIOD(4)) u_clk (.clk_o(clk));

  cpu_wrapper DUT (
    .clk        (clk),
    .rst_i      (rst_i),
    .halted_o   (halted_o),
    .m_awaddr_o (m_awaddr_o),
    .m_awvalid_o(m_awvalid_o),
    .m_awready_i(m_awready_i),
    .m_wdata_o  (m_wdata_o),
    .m_wstrb_o  (m_wstrb_o),
    .m_wvalid_o (m_wvalid_o),
    .m_wready_i (m_wready_i),
    .m_bresp_i  (m_bresp_i),
    .m_bvalid_i (m_bvalid_i),
    .m_bready_o (m_bready_o),
    .m_araddr_o (m_araddr_o),
    .m_arvalid_o(m_arvalid_o),
    .m_arready_i(m_arready_i),
    .m_rdata_i  (m_rdata_i),
    .m_rresp_i  (m_rresp_i),
    .m_rvalid_i (m_rvalid_i),
    .m_rready_o (m_rready_o)
  );

  task automatic fail_now(string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      fail_now($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Inputs change and outputs are read just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) next_cycle();
  endtask

  task automatic check_bus_idle(string when);
    check_value({"awvalid ", when}, 0, m_awvalid_o);
    check_value({"wvalid ", when}, 0, m_wvalid_o);
    check_value({"bready ", when}, 0, m_bready_o);
    check_value({"arvalid ", when}, 0, m_arvalid_o);
    check_value({"rready ", when}, 0, m_rready_o);
    check_value({"halted ", when}, 0, halted_o);
  endtask

  // RV32I encoders
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, int imm);
    return {imm[11:0], rs1, 3'h0, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lw(logic [4:0] rd, logic [4:0] rs1, int imm);
    return {imm[11:0], rs1, 3'h2, rd, OP_LOAD};
  endfunction

  function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, int imm);
    return {imm[11:5], rs2, rs1, 3'h2, imm[4:0], OP_STORE};
  endfunction

  task automatic load_program();
    // Fill first, so every word carries its own index
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {16'hfeed, 8'h00, 8'(i)};
    end
    prog.push_back(enc_addi(1, 0, 100));
    prog.push_back(enc_addi(2, 0, -37));
    prog.push_back(enc_r(7'h00, 3'h0, 3, 1, 2));
    prog.push_back(enc_r(7'h20, 3'h0, 4, 1, 2));
    prog.push_back(enc_r(7'h00, 3'h7, 5, 1, 2));
    prog.push_back(enc_r(7'h00, 3'h6, 6, 1, 2));
    prog.push_back(enc_r(7'h00, 3'h4, 7, 1, 2));
    prog.push_back(enc_addi(10, 0, DATA_BASE));
    prog.push_back(enc_sw(3, 10, 0));
    prog.push_back(enc_sw(4, 10, 4));
    prog.push_back(enc_sw(5, 10, 8));
    prog.push_back(enc_sw(6, 10, 12));
    // Negative store offset
    prog.push_back(enc_sw(7, 10, -4));
    // x0 must stay zero
    prog.push_back(enc_addi(0, 0, 55));
    prog.push_back(enc_sw(0, 10, 16));
    // Load back a stored word and reuse it
    prog.push_back(enc_lw(8, 10, 4));
    prog.push_back(enc_addi(9, 8, -1000));
    prog.push_back(enc_sw(9, 10, 20));
    prog.push_back(enc_sw(8, 10, -8));
    prog.push_back(enc_addi(11, 0, -2048));
    prog.push_back(enc_sw(11, 10, 24));
    prog.push_back(32'h0000_0000);
    foreach (prog[k]) begin
      mem[RESET_PC[9:2] + k] = prog[k];
    end
    ref_mem = mem;
  endtask

  // Instruction-level model, fills exp_addr/exp_data in store order
  function automatic int run_reference();
    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] ea;
    logic [XLEN-1:0] res;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic            stop;
    int              count;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = RESET_PC;
    count = 0;
    stop = 1'b0;
    while (!stop && count < REF_LIMIT) begin
      ins   = ref_mem[pc[9:2]];
      opc   = ins[6:0];
      f3    = ins[14:12];
      f7    = ins[31:25];
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      res   = '0;
      if (opc == OP_REG && f7 == 7'h00 && f3 == 3'h0) res = a + b;
      else if (opc == OP_REG && f7 == 7'h20 && f3 == 3'h0) res = a - b;
      else if (opc == OP_REG && f7 == 7'h00 && f3 == 3'h7) res = a & b;
      else if (opc == OP_REG && f7 == 7'h00 && f3 == 3'h6) res = a | b;
      else if (opc == OP_REG && f7 == 7'h00 && f3 == 3'h4) res = a ^ b;
      else if (opc == OP_IMM && f3 == 3'h0) res = a + imm_i;
      else if (opc == OP_LOAD && f3 == 3'h2) begin
        ea  = a + imm_i;
        res = ref_mem[ea[9:2]];
      end else if (opc == OP_STORE && f3 == 3'h2) begin
        ea = a + imm_s;
        ref_mem[ea[9:2]] = b;
        exp_addr.push_back(ea);
        exp_data.push_back(b);
      end else stop = 1'b1;
      if (!stop) begin
        // Stores write no register, x0 is never written
        if (opc != OP_STORE && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
        pc = pc + 4;
        count++;
      end
    end
    return count;
  endfunction

  task automatic do_read();
    logic [XLEN-1:0] raddr;
    int              ar_wait;
    int              cyc;
    bit              hs;
    ar_wait = $urandom % 4;
    cyc = 0;
    hs = 1'b0;
    while (!hs) begin
      m_arready_i = (cyc >= ar_wait);
      hs = m_arready_i && m_arvalid_o;
      if (hs) raddr = m_araddr_o;
      next_cycle();
      cyc++;
      if (!hs && cyc > HS_TIMEOUT) fail_now("Timeout on the read address handshake");
    end
    m_arready_i = 1'b0;
    if (first_read) begin
      check_value("first fetch address", RESET_PC, raddr);
      first_read = 1'b0;
    end
    if (raddr[31:10] != '0) fail_now($sformatf("Read outside the memory at %h", raddr));
    idle_cycles($urandom % 4);
    m_rdata_i  = mem[raddr[9:2]];
    m_rresp_i  = 2'b00;
    m_rvalid_i = 1'b1;
    cyc = 0;
    while (!m_rready_o) begin
      next_cycle();
      cyc++;
      if (cyc > HS_TIMEOUT) fail_now("Timeout waiting for RREADY");
    end
    // R handshake on this edge
    next_cycle();
    m_rvalid_i = 1'b0;
  endtask

  task automatic do_write();
    logic [XLEN-1:0] waddr;
    logic [XLEN-1:0] wdata;
    int              aw_wait;
    int              w_wait;
    int              cyc;
    bit              aw_done;
    bit              w_done;
    aw_wait = $urandom % 4;
    w_wait  = $urandom % 4;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cyc = 0;
    // AW and W accepted independently
    while (!(aw_done && w_done)) begin
      m_awready_i = !aw_done && (cyc >= aw_wait);
      m_wready_i  = !w_done && (cyc >= w_wait);
      if (m_awready_i && m_awvalid_o) begin
        waddr   = m_awaddr_o;
        aw_done = 1'b1;
      end
      if (m_wready_i && m_wvalid_o) begin
        wdata  = m_wdata_o;
        w_done = 1'b1;
        // Full-word stores only
        check_value("write strobe", {AXI_STRB_W{1'b1}}, m_wstrb_o);
      end
      next_cycle();
      cyc++;
      if (!(aw_done && w_done) && cyc > HS_TIMEOUT) fail_now("Timeout on the AW/W handshakes");
    end
    m_awready_i = 1'b0;
    m_wready_i  = 1'b0;
    if (waddr[31:10] != '0) fail_now($sformatf("Write outside the memory at %h", waddr));
    mem[waddr[9:2]] = wdata;
    idle_cycles($urandom % 4);
    m_bresp_i  = 2'b00;
    m_bvalid_i = 1'b1;
    cyc = 0;
    while (!m_bready_o) begin
      next_cycle();
      cyc++;
      if (cyc > HS_TIMEOUT) fail_now("Timeout waiting for BREADY");
    end
    next_cycle();
    m_bvalid_i = 1'b0;
  endtask

  // Memory slave, one transaction at a time
  task automatic serve_bus();
    forever begin
      next_cycle();
      if (m_arvalid_o) begin
        do_read();
      end else if (m_awvalid_o || m_wvalid_o) begin
        do_write();
      end
    end
  endtask

  // Compares each completed write, sampled mid-cycle
  task automatic watch_writes();
    forever begin
      @(negedge clk);
      if (m_bvalid_i && m_bready_o) begin
        if (n_writes >= exp_addr.size()) begin
          fail_now($sformatf("Unexpected extra bus write to %h", m_awaddr_o));
        end
        check_value($sformatf("write %0d address", n_writes), exp_addr[n_writes], m_awaddr_o);
        check_value($sformatf("write %0d data", n_writes), exp_data[n_writes], m_wdata_o);
        n_writes++;
      end
    end
  endtask

  initial begin : run_sequence
    int cyc;
    int n_exec;
    void'($urandom(SEED));
    rst_i       = 1'b1;
    m_awready_i = 1'b0;
    m_wready_i  = 1'b0;
    m_bresp_i   = 2'b00;
    m_bvalid_i  = 1'b0;
    m_arready_i = 1'b0;
    m_rdata_i   = '0;
    m_rresp_i   = 2'b00;
    m_rvalid_i  = 1'b0;
    n_writes    = 0;
    first_read  = 1'b1;
    load_program();
    n_exec = run_reference();
    $display("Reference ran %0d instructions, %0d writes", n_exec, exp_addr.size());
    repeat (8) begin
      next_cycle();
      check_bus_idle("during reset");
    end
    rst_i = 1'b0;
    next_cycle();
    check_bus_idle("after reset");
    fork
      serve_bus();
      watch_writes();
    join_none
    cyc = 0;
    while (!halted_o) begin
      next_cycle();
      cyc++;
      if (cyc > HALT_TIMEOUT) fail_now("Timeout waiting for the core to halt");
    end
    check_value("write count", exp_addr.size(), n_writes);
    // Halted core keeps the bus quiet
    repeat (QUIET_CYCLES) begin
      next_cycle();
      check_value("arvalid after halt", 0, m_arvalid_o);
      check_value("awvalid after halt", 0, m_awvalid_o);
      check_value("halted after halt", 1, halted_o);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen #(
  parameter int PERIOD = 4
) (
  output logic clk_o
);

  // Free-running, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- hw/cpu_wrapper.sv
`default_nettype none

module cpu_wrapper (
  input  logic                                clk,
  input  logic                                rst_i,
  output logic                                halted_o,
  output logic [axi_lite_pkg::AXI_ADDR_W-1:0] m_awaddr_o,
  output logic                                m_awvalid_o,
  input  logic                                m_awready_i,
  output logic [axi_lite_pkg::AXI_DATA_W-1:0] m_wdata_o,
  output logic [axi_lite_pkg::AXI_STRB_W-1:0] m_wstrb_o,
  output logic                                m_wvalid_o,
  input  logic                                m_wready_i,
  input  logic [1:0]                          m_bresp_i,
  input  logic                                m_bvalid_i,
  output logic                                m_bready_o,
  output logic [axi_lite_pkg::AXI_ADDR_W-1:0] m_araddr_o,
  output logic                                m_arvalid_o,
  input  logic                                m_arready_i,
  input  logic [axi_lite_pkg::AXI_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]                          m_rresp_i,
  input  logic                                m_rvalid_i,
  output logic                                m_rready_o
);
  import cpu_pkg::*;

  // Core to master request/done link
  logic            mem_req;
  logic            mem_we;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_done;
  logic [XLEN-1:0] mem_rdata;

  cpu_core u_core (
    .clk        (clk),
    .rst_i      (rst_i),
    .mem_done_i (mem_done),
    .mem_rdata_i(mem_rdata),
    .mem_req_o  (mem_req),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .halted_o   (halted_o)
  );

  // Fetches and data accesses share this master
  axi_lite_master u_master (
    .clk        (clk),
    .rst_i      (rst_i),
    .mem_req_i  (mem_req),
    .mem_we_i   (mem_we),
    .mem_addr_i (mem_addr),
    .mem_wdata_i(mem_wdata),
    .mem_done_o (mem_done),
    .mem_rdata_o(mem_rdata),
    .m_awaddr_o (m_awaddr_o),
    .m_awvalid_o(m_awvalid_o),
    .m_awready_i(m_awready_i),
    .m_wdata_o  (m_wdata_o),
    .m_wstrb_o  (m_wstrb_o),
    .m_wvalid_o (m_wvalid_o),
    .m_wready_i (m_wready_i),
    .m_bresp_i  (m_bresp_i),
    .m_bvalid_i (m_bvalid_i),
    .m_bready_o (m_bready_o),
    .m_araddr_o (m_araddr_o),
    .m_arvalid_o(m_arvalid_o),
    .m_arready_i(m_arready_i),
    .m_rdata_i  (m_rdata_i),
    .m_rresp_i  (m_rresp_i),
    .m_rvalid_i (m_rvalid_i),
    .m_rready_o (m_rready_o)
  );

endmodule

`default_nettype wire

//--- hw/axi_lite_master.sv
`default_nettype none

module axi_lite_master (
  input  logic                                clk,
  input  logic                                rst_i,
  input  logic                                mem_req_i,
  input  logic                                mem_we_i,
  input  logic [axi_lite_pkg::AXI_ADDR_W-1:0] mem_addr_i,
  input  logic [axi_lite_pkg::AXI_DATA_W-1:0] mem_wdata_i,
  output logic                                mem_done_o,
  output logic [axi_lite_pkg::AXI_DATA_W-1:0] mem_rdata_o,
  output logic [axi_lite_pkg::AXI_ADDR_W-1:0] m_awaddr_o,
  output logic                                m_awvalid_o,
  input  logic                                m_awready_i,
  output logic [axi_lite_pkg::AXI_DATA_W-1:0] m_wdata_o,
  output logic [axi_lite_pkg::AXI_STRB_W-1:0] m_wstrb_o,
  output logic                                m_wvalid_o,
  input  logic                                m_wready_i,
  input  logic [1:0]                          m_bresp_i,
  input  logic                                m_bvalid_i,
  output logic                                m_bready_o,
  output logic [axi_lite_pkg::AXI_ADDR_W-1:0] m_araddr_o,
  output logic                                m_arvalid_o,
  input  logic                                m_arready_i,
  input  logic [axi_lite_pkg::AXI_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]                          m_rresp_i,
  input  logic                                m_rvalid_i,
  output logic                                m_rready_o
);
  import axi_lite_pkg::*;

  axi_state_e            state_q;
  logic                  aw_done_q;
  logic                  w_done_q;
  logic                  done_q;
  logic [AXI_ADDR_W-1:0] addr_q;
  logic [AXI_DATA_W-1:0] wdata_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic                  aw_seen;
  logic                  w_seen;

  // AW and W complete independently
  assign m_awvalid_o = (state_q == M_WRITE) && !aw_done_q;
  assign m_wvalid_o  = (state_q == M_WRITE) && !w_done_q;
  assign m_bready_o  = (state_q == M_BRESP);
  assign m_arvalid_o = (state_q == M_RADDR);
  assign m_rready_o  = (state_q == M_RDATA);

  // Handshake done earlier or in this cycle
  assign aw_seen = aw_done_q || m_awready_i;
  assign w_seen  = w_done_q || m_wready_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= M_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        M_IDLE: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (mem_req_i) state_q <= mem_we_i ? M_WRITE : M_RADDR;
        end
        M_WRITE: begin
          if (m_awvalid_o && m_awready_i) aw_done_q <= 1'b1;
          if (m_wvalid_o && m_wready_i) w_done_q <= 1'b1;
          if (aw_seen && w_seen) state_q <= M_BRESP;
        end
        M_BRESP: begin
          if (m_bvalid_i) begin
            done_q  <= 1'b1;
            state_q <= M_IDLE;
          end
        end
        M_RADDR: if (m_arready_i) state_q <= M_RDATA;
        M_RDATA: begin
          if (m_rvalid_i) begin
            done_q  <= 1'b1;
            state_q <= M_IDLE;
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  // Request payload and read data
  always_ff @(posedge clk) begin
    if (state_q == M_IDLE && mem_req_i) begin
      addr_q  <= mem_addr_i;
      wdata_q <= mem_wdata_i;
    end
    if (m_rvalid_i && m_rready_o) begin
      rdata_q <= m_rdata_i;
    end
  end

  // One address register serves both channels
  assign m_awaddr_o  = addr_q;
  assign m_araddr_o  = addr_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = '1;
  assign mem_done_o  = done_q;
  assign mem_rdata_o = rdata_q;

  property p_valid_hold(valid, ready);
    @(posedge clk) disable iff (rst_i) (valid && !ready) |=> valid;
  endproperty

  a_aw_hold: assert property (p_valid_hold(m_awvalid_o, m_awready_i));
  a_w_hold:  assert property (p_valid_hold(m_wvalid_o, m_wready_i));
  a_ar_hold: assert property (p_valid_hold(m_arvalid_o, m_arready_i));

  // Core waits for done before the next request
  a_req_idle: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_i |-> (state_q == M_IDLE));

  // Responses ignored, but must be driven by the slave
  a_resp_known: assert property (@(posedge clk) disable iff (rst_i)
    (m_bvalid_i |-> !$isunknown(m_bresp_i)) and (m_rvalid_i |-> !$isunknown(m_rresp_i)));

endmodule

`default_nettype wire

//--- hw/cpu_core.sv
`default_nettype none

module cpu_core (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     mem_done_i,
  input  logic [cpu_pkg::XLEN-1:0] mem_rdata_i,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [cpu_pkg::XLEN-1:0] mem_addr_o,
  output logic [cpu_pkg::XLEN-1:0] mem_wdata_o,
  output logic                     halted_o
);
  import cpu_pkg::*;

  core_state_e           state_q;
  logic [XLEN-1:0]       pc_q;
  logic [XLEN-1:0]       ir_q;
  logic                  wait_q;
  logic                  req_q;
  logic                  issue;
  // Decode outputs
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  alu_op_e               alu_op;
  logic                  use_imm;
  logic                  is_load;
  logic                  is_store;
  logic                  wr_en;
  logic                  illegal;
  // Latched at end of S_DECODE
  logic [REG_ADDR_W-1:0] rd_q;
  logic [XLEN-1:0]       imm_q;
  alu_op_e               alu_op_q;
  logic                  use_imm_q;
  logic                  is_load_q;
  logic                  is_store_q;
  logic                  wr_en_q;
  // Operands, results and bus payload
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  logic [XLEN-1:0]       alu_result;
  logic [XLEN-1:0]       alu_q;
  logic [XLEN-1:0]       load_q;
  logic [XLEN-1:0]       addr_q;
  logic [XLEN-1:0]       wdata_q;
  logic                  we_q;

  instr_decode u_decode (
    .instr_i   (ir_q),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rd_o      (rd),
    .imm_o     (imm),
    .alu_op_o  (alu_op),
    .use_imm_o (use_imm),
    .is_load_o (is_load),
    .is_store_o(is_store),
    .wr_en_o   (wr_en),
    .illegal_o (illegal)
  );

  alu_execute u_execute (
    .rs1_val_i(rs1_val),
    .rs2_val_i(rs2_val),
    .imm_i    (imm_q),
    .alu_op_i (alu_op_q),
    .use_imm_i(use_imm_q),
    .result_o (alu_result)
  );

  // Register reads follow ir_q, which holds until the next fetch
  result_writeback u_result (
    .clk         (clk),
    .rst_i       (rst_i),
    .rs1_i       (rs1),
    .rs2_i       (rs2),
    .rd_i        (rd_q),
    .wr_en_i     ((state_q == S_WB) && wr_en_q),
    .is_load_i   (is_load_q),
    .alu_result_i(alu_q),
    .load_data_i (load_q),
    .rs1_val_o   (rs1_val),
    .rs2_val_o   (rs2_val)
  );

  // One request per visit to S_FETCH or S_MEM
  assign issue = ((state_q == S_FETCH) || (state_q == S_MEM)) && !wait_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_FETCH;
      pc_q    <= RESET_PC;
      wait_q  <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      req_q <= issue;
      if (issue) begin
        wait_q <= 1'b1;
      end else if (mem_done_i) begin
        wait_q <= 1'b0;
      end
      case (state_q)
        S_FETCH:  if (wait_q && mem_done_i) state_q <= S_DECODE;
        S_DECODE: state_q <= illegal ? S_HALT : S_EXEC;
        S_EXEC:   state_q <= (is_load_q || is_store_q) ? S_MEM : S_WB;
        S_MEM:    if (wait_q && mem_done_i) state_q <= S_WB;
        S_WB: begin
          pc_q    <= pc_q + XLEN'(4);
          state_q <= S_FETCH;
        end
        default:  state_q <= S_HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_FETCH && mem_done_i) begin
      ir_q <= mem_rdata_i;
    end
    if (state_q == S_DECODE) begin
      rd_q       <= rd;
      imm_q      <= imm;
      alu_op_q   <= alu_op;
      use_imm_q  <= use_imm;
      is_load_q  <= is_load;
      is_store_q <= is_store;
      wr_en_q    <= wr_en;
    end
    if (state_q == S_EXEC) begin
      alu_q   <= alu_result;
      wdata_q <= rs2_val;
    end
    if (state_q == S_MEM && mem_done_i) begin
      load_q <= mem_rdata_i;
    end
    // Fetch uses the PC, data access the computed address
    if (issue) begin
      addr_q <= (state_q == S_MEM) ? alu_q : pc_q;
      we_q   <= (state_q == S_MEM) && is_store_q;
    end
  end

  assign mem_req_o   = req_q;
  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;
  assign halted_o    = (state_q == S_HALT);

  // Single-cycle request pulse
  a_req_pulse: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_o |=> !mem_req_o);

  // Halted core stays off the bus
  a_halt_quiet: assert property (@(posedge clk) disable iff (rst_i)
    (state_q == S_HALT) |-> !mem_req_o);

endmodule

`default_nettype wire

//--- hw/result_writeback.sv
`default_nettype none

module result_writeback (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                           wr_en_i,
  input  logic                           is_load_i,
  input  logic [cpu_pkg::XLEN-1:0]       alu_result_i,
  input  logic [cpu_pkg::XLEN-1:0]       load_data_i,
  output logic [cpu_pkg::XLEN-1:0]       rs1_val_o,
  output logic [cpu_pkg::XLEN-1:0]       rs2_val_o
);
  import cpu_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];
  logic [XLEN-1:0] wr_data;

  // Loads return memory data, everything else the ALU result
  assign wr_data = is_load_i ? load_data_i : alu_result_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (rd_i != '0)) begin
      regs[rd_i] <= wr_data;
    end
  end

  // Async read, x0 hardwired to zero
  assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- hw/alu_execute.sv
`default_nettype none

module alu_execute (
  input  logic [cpu_pkg::XLEN-1:0] rs1_val_i,
  input  logic [cpu_pkg::XLEN-1:0] rs2_val_i,
  input  logic [cpu_pkg::XLEN-1:0] imm_i,
  input  cpu_pkg::alu_op_e         alu_op_i,
  input  logic                     use_imm_i,
  output logic [cpu_pkg::XLEN-1:0] result_o
);
  import cpu_pkg::*;

  logic [XLEN-1:0] operand_b;

  // ADDI, LW and SW take the immediate
  assign operand_b = use_imm_i ? imm_i : rs2_val_i;

  // Address for LW/SW is formed here as well, decode forces ALU_ADD
  always_comb begin
    case (alu_op_i)
      ALU_ADD: result_o = rs1_val_i + operand_b;
      ALU_SUB: result_o = rs1_val_i - operand_b;
      ALU_AND: result_o = rs1_val_i & operand_b;
      ALU_OR:  result_o = rs1_val_i | operand_b;
      ALU_XOR: result_o = rs1_val_i ^ operand_b;
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/instr_decode.sv
`default_nettype none

module instr_decode (
  input  logic [cpu_pkg::XLEN-1:0]       instr_i,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [cpu_pkg::XLEN-1:0]       imm_o,
  output cpu_pkg::alu_op_e               alu_op_o,
  output logic                           use_imm_o,
  output logic                           is_load_o,
  output logic                           is_store_o,
  output logic                           wr_en_o,
  output logic                           illegal_o
);
  import cpu_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Fixed RV32I field positions
  assign opcode = opcode_e'(instr_i[6:0]);
  assign rd_o   = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  always_comb begin
    alu_op_o   = ALU_ADD;
    imm_o      = '0;
    use_imm_o  = 1'b0;
    is_load_o  = 1'b0;
    is_store_o = 1'b0;
    wr_en_o    = 1'b0;
    illegal_o  = 1'b0;
    case (opcode)
      OP_REG: begin
        wr_en_o = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'h0}: alu_op_o = ALU_ADD;
          {7'h20, 3'h0}: alu_op_o = ALU_SUB;
          {7'h00, 3'h4}: alu_op_o = ALU_XOR;
          {7'h00, 3'h6}: alu_op_o = ALU_OR;
          {7'h00, 3'h7}: alu_op_o = ALU_AND;
          default: begin
            wr_en_o   = 1'b0;
            illegal_o = 1'b1;
          end
        endcase
      end
      OP_IMM: begin
        // ADDI only, I-type immediate
        imm_o     = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
        use_imm_o = 1'b1;
        wr_en_o   = (funct3 == 3'h0);
        illegal_o = (funct3 != 3'h0);
      end
      OP_LOAD: begin
        // LW only
        imm_o     = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
        use_imm_o = 1'b1;
        is_load_o = (funct3 == 3'h2);
        wr_en_o   = (funct3 == 3'h2);
        illegal_o = (funct3 != 3'h2);
      end
      OP_STORE: begin
        // SW only, S-type immediate split across two fields
        imm_o      = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        use_imm_o  = 1'b1;
        is_store_o = (funct3 == 3'h2);
        illegal_o  = (funct3 != 3'h2);
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

  // Bus widths
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // Master transaction states
  typedef enum logic [2:0] {
    M_IDLE,
    M_WRITE,
    M_BRESP,
    M_RADDR,
    M_RDATA
  } axi_state_e;

endpackage

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Datapath and address width
  localparam int XLEN = 32;

  // Register file geometry
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 32;

  // First fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP_REG   = 7'b0110011,
    OP_IMM   = 7'b0010011,
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } opcode_e;

  // ALU functions
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // Instruction sequencing, one step per state
  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_WB,
    S_HALT
  } core_state_e;

endpackage

`default_nettype wire
